//--- files.f
design/tmu_pkg.sv
design/tmu_apb_regs.sv
design/tmu_ctrl_fsm.sv
design/tmu_pixel_counter.sv
design/tmu_pixel_ram.sv
design/tmu_decay.sv
design/tmu_top.sv
dv/tmu_assertions.sv
dv/tmu_tb.sv

//--- Bender.yml
package:
  name: tmu

sources:
  - design/tmu_pkg.sv
  - design/tmu_apb_regs.sv
  - design/tmu_ctrl_fsm.sv
  - design/tmu_pixel_counter.sv
  - design/tmu_pixel_ram.sv
  - design/tmu_decay.sv
  - design/tmu_top.sv
  - target: simulation
    files:
      - dv/tmu_assertions.sv
      - dv/tmu_tb.sv

//--- dv/tmu_tb.sv
// Testbench for the frame-decay engine with APB tasks, LCG stimulus and a reference model
`timescale 1ns/1ps

module tmu_tb;

	logic                        sys_clk = 1'b0;
	logic                        sys_rst = 1'b1;
	logic [tmu_pkg::APB_AW-1:0]  paddr   = '0;
	logic                        psel    = 1'b0;
	logic                        penable = 1'b0;
	logic                        pwrite  = 1'b0;
	logic [tmu_pkg::APB_DW-1:0]  pwdata  = '0;
	logic [tmu_pkg::APB_DW-1:0]  prdata;
	logic                        pready;
	logic                        pslverr;
	logic [31:0]                 seed = 32'h213f;       // LCG state
	logic [tmu_pkg::PIX_W-1:0]   src     [64];          // Source frame as loaded
	logic [tmu_pkg::PIX_W-1:0]   exp_dst [64];          // Expected destination frame
	logic [31:0]                 rd;                    // Last APB read data
	logic                        err;                   // Last APB slave error

	tmu_top i_tmu_top (.sys_clk(sys_clk), .sys_rst(sys_rst), .paddr_i(paddr), .psel_i(psel),
		.penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr));

	always #5 sys_clk = ~sys_clk;                       // 100 MHz

	function logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Channel times (level + 1) over 64 rounded down with full level passing through
	function automatic logic [15:0] decay_pixel(logic [15:0] p, logic [5:0] b);
		int m;
		m = b + 1;
		if (b == tmu_pkg::FULL_BRIGHTNESS)
			return p;
		return {5'(p[15:11] * m / 64), 6'(p[10:5] * m / 64), 5'(p[4:0] * m / 64)};
	endfunction

	function automatic logic [15:0] fill_word(int i, int run_id);
		return 16'(i * 16'h0407) ^ 16'h5a3c ^ 16'(run_id << 12); // Odd multiplier spreads addr
	endfunction

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic apb_xfer(logic [11:0] addr, logic wr, logic [31:0] wdata);
		int   t;
		logic win;                                      // Address inside a RAM window
		logic mapped;
		win    = (addr >= tmu_pkg::SRC_BASE &&
			addr < tmu_pkg::SRC_BASE + 4 * tmu_pkg::FB_DEPTH) ||
			(addr >= tmu_pkg::DST_BASE &&
			addr < tmu_pkg::DST_BASE + 4 * tmu_pkg::FB_DEPTH);
		mapped = win || addr inside {tmu_pkg::REG_CTRL, tmu_pkg::REG_BRIGHT, tmu_pkg::REG_CKEY,
			tmu_pkg::REG_COUNT, tmu_pkg::REG_STATUS};
		repeat ((next_rand() >> 16) % 3) @(posedge sys_clk); // Random idle gap
		@(posedge sys_clk);
		paddr  <= addr;                                 // Setup phase
		pwrite <= wr;
		pwdata <= wdata;
		psel   <= 1'b1;
		@(posedge sys_clk);
		penable <= 1'b1;
		t = 0;
		do begin
			@(posedge sys_clk);
			t++;
		end while (!pready && t < 8);
		if (!pready) begin
			$display("APB transfer to address %h never completed", addr);
			$display("*** FAILED ***");
			$fatal(1);
		end
		rd      = prdata;
		err     = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
		check_eq($sformatf("wait states at %h", addr), win ? 32'd2 : 32'd1, 32'(t));
		check_eq($sformatf("pslverr at %h", addr), {31'd0, ~mapped}, {31'd0, err});
	endtask

	task automatic apb_write(logic [11:0] addr, logic [31:0] wdata);
		apb_xfer(addr, 1'b1, wdata);
	endtask

	task automatic apb_read(logic [11:0] addr);
		apb_xfer(addr, 1'b0, 32'd0);
	endtask

	task automatic run_frame(string name, logic [5:0] bright, logic key_en, int count,
		bit stall, int run_id);
		logic [15:0] key;
		int          t;
		key = 16'(next_rand() >> 8);
		apb_write(tmu_pkg::REG_BRIGHT, 32'(bright));
		apb_write(tmu_pkg::REG_CKEY, {15'd0, key_en, key});
		apb_write(tmu_pkg::REG_COUNT, 32'(count));
		for (int i = 0; i < 64; i++) begin
			src[i]     = (key_en && (next_rand() >> 20) % 4 == 0) ? key : 16'(next_rand() >> 8);
			exp_dst[i] = fill_word(i, run_id);
			apb_write(12'(tmu_pkg::SRC_BASE + 4 * i), 32'(src[i]));
			apb_write(12'(tmu_pkg::DST_BASE + 4 * i), 32'(exp_dst[i]));
			if (i < count && !(key_en && src[i] == key))
				exp_dst[i] = decay_pixel(src[i], bright);  // Keyed or uncounted words keep fill
		end
		apb_write(tmu_pkg::REG_CTRL, 32'd1);
		apb_read(tmu_pkg::REG_STATUS);
		check_eq({name, " busy"}, 32'd1, rd);
		if (stall)
			apb_write(tmu_pkg::SRC_BASE, 32'(~src[0])); // Frame locked while busy
		t = 0;
		do begin
			if (stall)
				apb_read(12'(tmu_pkg::DST_BASE + 4 * (t % 64))); // Steals the dst port
			apb_read(tmu_pkg::REG_STATUS);
			t++;
		end while (rd != 32'd2 && t < 200);
		if (rd != 32'd2) begin
			$display("%s: run did not report done before the timeout", name);
			$display("*** FAILED ***");
			$fatal(1);
		end
		if (stall) begin
			apb_read(tmu_pkg::SRC_BASE);
			check_eq({name, " src locked"}, 32'(src[0]), rd);
		end
		for (int i = 0; i < 64; i++) begin
			apb_read(12'(tmu_pkg::DST_BASE + 4 * i));
			check_eq($sformatf("%s dst[%0d]", name, i), 32'(exp_dst[i]), rd);
		end
	endtask

	// Bound protocol checks stop the run at once
	always @(posedge sys_clk) begin
		if (i_tmu_top.i_tmu_assertions.err_count != 0) begin
			$display("*** FAILED ***");
			$fatal(1, "Protocol assertion failed");
		end
	end

	initial begin
		repeat (2) @(posedge sys_clk);
		sys_rst <= 1'b0;
		apb_write(tmu_pkg::REG_BRIGHT, 32'h2a);
		apb_read(tmu_pkg::REG_BRIGHT);
		check_eq("bright readback", 32'h2a, rd);
		apb_write(tmu_pkg::REG_CKEY, 32'h1_beef);
		apb_read(tmu_pkg::REG_CKEY);
		check_eq("ckey readback", 32'h1_beef, rd);
		apb_write(tmu_pkg::REG_COUNT, 32'd37);
		apb_read(tmu_pkg::REG_COUNT);
		check_eq("count readback", 32'd37, rd);
		apb_write(tmu_pkg::REG_STATUS, 32'h3);          // Read-only
		apb_read(tmu_pkg::REG_STATUS);
		check_eq("status write ignored", 32'h0, rd);
		apb_read(12'h020);
		check_eq("unmapped pslverr", 32'd1, {31'd0, err});
		run_frame("scaling", 6'((next_rand() >> 16) % 63), 1'b0, 64, 1'b0, 1);
		run_frame("pass-through", 6'd63, 1'b0, 64, 1'b0, 2);
		run_frame("chroma key", 6'd40, 1'b1, 64, 1'b0, 3);
		run_frame("back-pressure", 6'd21, 1'b0, 64, 1'b1, 4);
		run_frame("partial count", 6'd50, 1'b1, 20, 1'b0, 5);
		if (i_tmu_top.i_tmu_assertions.err_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1, "Protocol assertion failed");
		end
	end

endmodule

//--- dv/tmu_assertions.sv
// Concurrent checks on APB, the pipeline output handshake and run status, with bind
`timescale 1ns/1ps

module tmu_assertions (
	input logic                        sys_clk,
	input logic                        sys_rst,
	input logic                        psel_i,
	input logic                        penable_i,
	input logic                        pready_o,
	input logic                        pslverr_o,
	input logic                        start,
	input logic                        pipe_stb,
	input logic                        pipe_ack,
	input logic [tmu_pkg::PIX_W-1:0]   pipe_pixel,
	input logic [tmu_pkg::FB_AW-1:0]   pipe_addr,
	input logic                        busy,
	input logic                        done
);

	int err_count = 0;   // Failures so far

	ready_in_access: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pready_o |-> psel_i && penable_i)
		else begin
			err_count++;
			$error("pready high outside an access phase");
		end

	slverr_with_ready: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pslverr_o |-> pready_o)
		else begin
			err_count++;
			$error("pslverr high without pready");
		end

	out_held_on_stall: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb && !pipe_ack |=> pipe_stb && $stable(pipe_pixel) && $stable(pipe_addr))
		else begin
			err_count++;
			$error("pipeline output moved while ack was low");
		end

	busy_done_apart: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!(busy && done))
		else begin
			err_count++;
			$error("busy and done high together");
		end

	start_is_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		start |=> !start)
		else begin
			err_count++;
			$error("start held longer than one cycle");
		end

endmodule

bind tmu_top tmu_assertions i_tmu_assertions (.*);

//--- design/tmu_top.sv
// Frame-decay engine top with APB registers, control, RAMs and decay pipeline
`timescale 1ns/1ps

module tmu_top (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic [tmu_pkg::APB_AW-1:0]  paddr_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic                        pwrite_i,
	input  logic [tmu_pkg::APB_DW-1:0]  pwdata_i,
	output logic [tmu_pkg::APB_DW-1:0]  prdata_o,
	output logic                        pready_o,
	output logic                        pslverr_o
);

	logic                           start;
	logic                           run;
	logic                           busy;
	logic                           done;
	logic [tmu_pkg::BRIGHT_W-1:0]   brightness;
	logic [tmu_pkg::PIX_W-1:0]      ckey;
	logic                           ckey_en;
	logic [tmu_pkg::CNT_W-1:0]      count;

	logic                           apb_src_we;
	logic [tmu_pkg::FB_AW-1:0]      apb_src_addr;
	logic [tmu_pkg::PIX_W-1:0]      apb_src_wdata;
	logic                           dst_access;
	logic                           apb_dst_we;
	logic [tmu_pkg::FB_AW-1:0]      apb_dst_addr;
	logic [tmu_pkg::PIX_W-1:0]      apb_dst_wdata;

	logic [tmu_pkg::FB_AW-1:0]      src_addr;
	logic [tmu_pkg::PIX_W-1:0]      src_rdata;
	logic                           dst_we;
	logic [tmu_pkg::FB_AW-1:0]      dst_addr;
	logic [tmu_pkg::PIX_W-1:0]      dst_wdata;
	logic [tmu_pkg::PIX_W-1:0]      dst_rdata;

	logic [tmu_pkg::FB_AW-1:0]      cnt_addr;
	logic                           cnt_stb;
	logic                           cnt_last;
	logic [tmu_pkg::FB_AW-1:0]      pipe_in_addr;
	logic                           pipe_ack;     // Downstream ack
	logic                           up_ack;       // Ack seen by the counter
	logic                           pipe_stb;
	logic [tmu_pkg::PIX_W-1:0]      pipe_pixel;
	logic [tmu_pkg::FB_AW-1:0]      pipe_addr;
	logic                           decay_busy;

	// Source port belongs to the counter for the whole run and drain
	assign src_addr = busy ? cnt_addr : apb_src_addr;

	// An APB window access takes the destination port and stalls the pipeline
	assign pipe_ack  = ~dst_access;
	assign dst_we    = dst_access ? apb_dst_we : (pipe_stb & pipe_ack);
	assign dst_addr  = dst_access ? apb_dst_addr : pipe_addr;
	assign dst_wdata = dst_access ? apb_dst_wdata : pipe_pixel;

	// Read data belongs to the index issued one enabled cycle earlier
	assign pipe_in_addr = cnt_addr - 1'b1;

	tmu_apb_regs i_apb_regs (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.paddr_i      (paddr_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.pwdata_i     (pwdata_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.busy_i       (busy),
		.done_i       (done),
		.start_o      (start),
		.brightness_o (brightness),
		.ckey_o       (ckey),
		.ckey_en_o    (ckey_en),
		.count_o      (count),
		.src_we_o     (apb_src_we),
		.src_addr_o   (apb_src_addr),
		.src_wdata_o  (apb_src_wdata),
		.dst_access_o (dst_access),
		.dst_we_o     (apb_dst_we),
		.dst_addr_o   (apb_dst_addr),
		.dst_wdata_o  (apb_dst_wdata),
		.src_rdata_i  (src_rdata),
		.dst_rdata_i  (dst_rdata)
	);

	tmu_ctrl_fsm i_ctrl_fsm (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.start_i     (start),
		.last_i      (cnt_last),
		.pipe_busy_i (decay_busy | cnt_stb),    // Includes a strobe still waiting
		.run_o       (run),
		.busy_o      (busy),
		.done_o      (done)
	);

	tmu_pixel_counter i_pixel_counter (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.run_i     (run),
		.en_i      (up_ack),
		.count_i   (count),
		.rd_addr_o (cnt_addr),
		.stb_o     (cnt_stb),
		.last_o    (cnt_last)
	);

	tmu_pixel_ram i_src_ram (
		.sys_clk (sys_clk),
		.addr_i  (src_addr),
		.we_i    (apb_src_we),
		.wdata_i (apb_src_wdata),
		.rdata_o (src_rdata)
	);

	tmu_pixel_ram i_dst_ram (
		.sys_clk (sys_clk),
		.addr_i  (dst_addr),
		.we_i    (dst_we),
		.wdata_i (dst_wdata),
		.rdata_o (dst_rdata)
	);

	tmu_decay i_decay (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.brightness_i (brightness),
		.ckey_en_i    (ckey_en),
		.ckey_i       (ckey),
		.pipe_stb_i   (cnt_stb),
		.pipe_ack_o   (up_ack),
		.src_pixel_i  (src_rdata),
		.dst_addr_i   (pipe_in_addr),
		.pipe_stb_o   (pipe_stb),
		.pipe_ack_i   (pipe_ack),
		.pixel_o      (pipe_pixel),
		.dst_addr_o   (pipe_addr),
		.busy_o       (decay_busy)
	);

endmodule

//--- design/tmu_decay.sv
// Three-stage brightness scaling and chroma-key pipeline with strobe/ack flow
`timescale 1ns/1ps

module tmu_decay (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic [tmu_pkg::BRIGHT_W-1:0]  brightness_i,
	input  logic                          ckey_en_i,
	input  logic [tmu_pkg::PIX_W-1:0]     ckey_i,
	input  logic                          pipe_stb_i,
	output logic                          pipe_ack_o,
	input  logic [tmu_pkg::PIX_W-1:0]     src_pixel_i,
	input  logic [tmu_pkg::FB_AW-1:0]     dst_addr_i,
	output logic                          pipe_stb_o,
	input  logic                          pipe_ack_i,
	output logic [tmu_pkg::PIX_W-1:0]     pixel_o,
	output logic [tmu_pkg::FB_AW-1:0]     dst_addr_o,
	output logic                          busy_o
);

	logic                            en;
	logic                            s1_valid;
	logic                            s2_valid;
	logic                            s3_valid;

	logic [4:0]                      s1_r;
	logic [5:0]                      s1_g;
	logic [4:0]                      s1_b;
	logic [tmu_pkg::BRIGHT_W-1:0]    s1_mult;      // Brightness plus one
	logic                            s1_full;
	logic [tmu_pkg::PIX_W-1:0]       s1_pixel;
	logic [tmu_pkg::FB_AW-1:0]       s1_addr;

	logic [10:0]                     s2_r;
	logic [11:0]                     s2_g;
	logic [10:0]                     s2_b;
	logic                            s2_full;
	logic [tmu_pkg::PIX_W-1:0]       s2_pixel;
	logic [tmu_pkg::FB_AW-1:0]       s2_addr;

	assign en = pipe_ack_i;              // Whole pipeline moves together

	// Keyed pixels lose their valid bit entering stage 2
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else if (en) begin
			s1_valid <= pipe_stb_i;
			s2_valid <= s1_valid & (~ckey_en_i | (s1_pixel != ckey_i));
			s3_valid <= s2_valid;
		end
	end

	// Datapath
	always_ff @(posedge sys_clk) begin
		if (en) begin
			s1_r     <= src_pixel_i[15:11];
			s1_g     <= src_pixel_i[10:5];
			s1_b     <= src_pixel_i[4:0];
			s1_mult  <= brightness_i + 1'b1; // Wraps at full level where it is unused
			s1_full  <= (brightness_i == tmu_pkg::FULL_BRIGHTNESS);
			s1_pixel <= src_pixel_i;
			s1_addr  <= dst_addr_i;

			s2_r     <= s1_r * s1_mult;
			s2_g     <= s1_g * s1_mult;
			s2_b     <= s1_b * s1_mult;
			s2_full  <= s1_full;
			s2_pixel <= s1_pixel;
			s2_addr  <= s1_addr;

			// Top bits of each product divide by 64
			pixel_o    <= s2_full ? s2_pixel : {s2_r[10:6], s2_g[11:6], s2_b[10:6]};
			dst_addr_o <= s2_addr;
		end
	end

	assign pipe_stb_o = s3_valid;
	assign pipe_ack_o = pipe_ack_i;
	assign busy_o     = s1_valid | s2_valid | s3_valid;

endmodule

//--- design/tmu_pixel_ram.sv
// Single-port 64 x 16 synchronous pixel memory with registered read
`timescale 1ns/1ps

module tmu_pixel_ram (
	input  logic                       sys_clk,
	input  logic [tmu_pkg::FB_AW-1:0]  addr_i,
	input  logic                       we_i,
	input  logic [tmu_pkg::PIX_W-1:0]  wdata_i,
	output logic [tmu_pkg::PIX_W-1:0]  rdata_o
);

	logic [tmu_pkg::PIX_W-1:0] mem [tmu_pkg::FB_DEPTH];

	always_ff @(posedge sys_clk) begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];              // Old data on a write cycle
	end

endmodule

//--- design/tmu_pixel_counter.sv
// Pixel index counter driving source RAM reads and the pipeline input strobe
`timescale 1ns/1ps

module tmu_pixel_counter (
	input  logic                       sys_clk,
	input  logic                       sys_rst,
	input  logic                       run_i,
	input  logic                       en_i,       // Pipeline ack
	input  logic [tmu_pkg::CNT_W-1:0]  count_i,
	output logic [tmu_pkg::FB_AW-1:0]  rd_addr_o,
	output logic                       stb_o,      // Read data valid at pipeline input
	output logic                       last_o
);

	logic [tmu_pkg::FB_AW-1:0] idx_q;  // Next index to issue
	logic                      stb_q;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			idx_q <= '0;
			stb_q <= 1'b0;
		end else begin
			if (en_i) begin
				stb_q <= run_i;                 // One cycle behind the issue
				if (run_i)
					idx_q <= idx_q + 1'b1;
			end
			if (!run_i && !stb_q)
				idx_q <= '0;                    // Ready for the next run
		end
	end

	// On a stall the pixel already in the read register is addressed again
	// so the registered read data holds
	assign rd_addr_o = en_i ? idx_q : idx_q - 1'b1;
	assign stb_o     = stb_q;
	assign last_o    = run_i & en_i & (({1'b0, idx_q} + 1'b1) >= count_i);

endmodule

//--- design/tmu_ctrl_fsm.sv
// Run sequencer for start, pixel streaming, pipeline drain and completion
`timescale 1ns/1ps

module tmu_ctrl_fsm (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic start_i,
	input  logic last_i,       // Final pixel issued this cycle
	input  logic pipe_busy_i,  // Pipeline or input strobe still holds a pixel
	output logic run_o,
	output logic busy_o,
	output logic done_o
);

	tmu_pkg::tmu_state_e state_q;
	tmu_pkg::tmu_state_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			tmu_pkg::ST_IDLE: begin
				if (start_i)
					state_d = tmu_pkg::ST_RUN;
			end
			tmu_pkg::ST_RUN: begin
				if (last_i)
					state_d = tmu_pkg::ST_DRAIN;
			end
			tmu_pkg::ST_DRAIN: begin
				if (!pipe_busy_i)
					state_d = tmu_pkg::ST_DONE;  // Last write has landed
			end
			tmu_pkg::ST_DONE: begin
				if (start_i)
					state_d = tmu_pkg::ST_RUN;   // Done flag held until here
			end
			default: state_d = tmu_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state_q <= tmu_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	assign run_o  = (state_q == tmu_pkg::ST_RUN);
	assign busy_o = (state_q == tmu_pkg::ST_RUN) | (state_q == tmu_pkg::ST_DRAIN);
	assign done_o = (state_q == tmu_pkg::ST_DONE);

endmodule

//--- design/tmu_apb_regs.sv
// APB slave with configuration and status registers and the RAM window decode
`timescale 1ns/1ps

module tmu_apb_regs (
	input  logic                                 sys_clk,
	input  logic                                 sys_rst,
	input  logic [tmu_pkg::APB_AW-1:0]           paddr_i,
	input  logic                                 psel_i,
	input  logic                                 penable_i,
	input  logic                                 pwrite_i,
	input  logic [tmu_pkg::APB_DW-1:0]           pwdata_i,
	output logic [tmu_pkg::APB_DW-1:0]           prdata_o,
	output logic                                 pready_o,
	output logic                                 pslverr_o,
	input  logic                                 busy_i,
	input  logic                                 done_i,
	output logic                                 start_o,
	output logic [tmu_pkg::BRIGHT_W-1:0]         brightness_o,
	output logic [tmu_pkg::PIX_W-1:0]            ckey_o,
	output logic                                 ckey_en_o,
	output logic [tmu_pkg::CNT_W-1:0]            count_o,
	output logic                                 src_we_o,
	output logic [tmu_pkg::FB_AW-1:0]            src_addr_o,
	output logic [tmu_pkg::PIX_W-1:0]            src_wdata_o,
	output logic                                 dst_access_o,
	output logic                                 dst_we_o,
	output logic [tmu_pkg::FB_AW-1:0]            dst_addr_o,
	output logic [tmu_pkg::PIX_W-1:0]            dst_wdata_o,
	input  logic [tmu_pkg::PIX_W-1:0]            src_rdata_i,
	input  logic [tmu_pkg::PIX_W-1:0]            dst_rdata_i
);

	logic                          access;   // APB access phase
	logic                          src_hit;
	logic                          dst_hit;
	logic                          win_hit;
	logic                          reg_hit;
	logic                          reg_wr;
	logic                          wait_q;   // Second cycle of a window access
	logic [tmu_pkg::APB_AW-1:0]    win_base;

	assign access   = psel_i & penable_i;
	assign win_base = {paddr_i[tmu_pkg::APB_AW-1:tmu_pkg::WIN_LSB], {tmu_pkg::WIN_LSB{1'b0}}};
	assign src_hit  = (win_base == tmu_pkg::SRC_BASE);
	assign dst_hit  = (win_base == tmu_pkg::DST_BASE);
	assign win_hit  = src_hit | dst_hit;
	assign reg_hit  = (paddr_i == tmu_pkg::REG_CTRL) | (paddr_i == tmu_pkg::REG_BRIGHT) |
		(paddr_i == tmu_pkg::REG_CKEY) | (paddr_i == tmu_pkg::REG_COUNT) |
		(paddr_i == tmu_pkg::REG_STATUS);
	assign reg_wr   = access & pwrite_i & reg_hit;   // Registers finish in one access cycle

	// Window accesses wait one cycle for the RAM read register
	assign pready_o  = access & (~win_hit | wait_q);
	assign pslverr_o = access & ~reg_hit & ~win_hit;

	// RAM ports are driven only in the first access cycle
	assign src_we_o     = access & ~wait_q & src_hit & pwrite_i & ~busy_i; // Frame locked while busy
	assign src_addr_o   = paddr_i[tmu_pkg::WIN_LSB-1:2];
	assign src_wdata_o  = pwdata_i[tmu_pkg::PIX_W-1:0];
	assign dst_access_o = access & ~wait_q & dst_hit;                      // Steals the dst port
	assign dst_we_o     = dst_access_o & pwrite_i;
	assign dst_addr_o   = paddr_i[tmu_pkg::WIN_LSB-1:2];
	assign dst_wdata_o  = pwdata_i[tmu_pkg::PIX_W-1:0];

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wait_q       <= 1'b0;
			start_o      <= 1'b0;
			brightness_o <= tmu_pkg::FULL_BRIGHTNESS;
			ckey_o       <= '0;
			ckey_en_o    <= 1'b0;
			count_o      <= tmu_pkg::CNT_W'(tmu_pkg::FB_DEPTH); // Whole frame
		end else begin
			wait_q  <= access & win_hit & ~wait_q;
			start_o <= reg_wr & (paddr_i == tmu_pkg::REG_CTRL) & pwdata_i[0] & ~busy_i;
			if (reg_wr && paddr_i == tmu_pkg::REG_BRIGHT)
				brightness_o <= pwdata_i[tmu_pkg::BRIGHT_W-1:0];
			if (reg_wr && paddr_i == tmu_pkg::REG_CKEY) begin
				ckey_o    <= pwdata_i[tmu_pkg::PIX_W-1:0];
				ckey_en_o <= pwdata_i[tmu_pkg::PIX_W];          // Enable sits above the key
			end
			if (reg_wr && paddr_i == tmu_pkg::REG_COUNT)
				count_o <= pwdata_i[tmu_pkg::CNT_W-1:0];
		end
	end

	always_comb begin
		prdata_o = '0;
		if (src_hit) begin
			prdata_o[tmu_pkg::PIX_W-1:0] = src_rdata_i;
		end else if (dst_hit) begin
			prdata_o[tmu_pkg::PIX_W-1:0] = dst_rdata_i;
		end else begin
			case (paddr_i)
				tmu_pkg::REG_BRIGHT: prdata_o[tmu_pkg::BRIGHT_W-1:0] = brightness_o;
				tmu_pkg::REG_CKEY:   prdata_o[tmu_pkg::PIX_W:0] = {ckey_en_o, ckey_o};
				tmu_pkg::REG_COUNT:  prdata_o[tmu_pkg::CNT_W-1:0] = count_o;
				tmu_pkg::REG_STATUS: prdata_o[1:0] = {done_i, busy_i};
				default:             prdata_o = '0;          // CTRL reads as zero
			endcase
		end
	end

endmodule

//--- design/tmu_pkg.sv
// Frame sizes, APB register map, window bases and the run state type
package tmu_pkg;

	localparam int FB_AW    = 6;                 // Pixel address width
	localparam int FB_DEPTH = 1 << FB_AW;        // Words per frame
	localparam int PIX_W    = 16;                // RGB565 pixel
	localparam int BRIGHT_W = 6;                 // Brightness level width
	localparam int CNT_W    = FB_AW + 1;         // Pixel count 1 to FB_DEPTH

	localparam logic [BRIGHT_W-1:0] FULL_BRIGHTNESS = 6'd63; // Pass-through level

	localparam int APB_AW  = 12;                 // APB byte address width
	localparam int APB_DW  = 32;                 // APB data width
	localparam int WIN_LSB = FB_AW + 2;          // Low bit of the window select

	// Register offsets
	localparam logic [APB_AW-1:0] REG_CTRL   = 12'h000; // Bit 0 starts a run
	localparam logic [APB_AW-1:0] REG_BRIGHT = 12'h004;
	localparam logic [APB_AW-1:0] REG_CKEY   = 12'h008; // Key in 15:0 and enable in 16
	localparam logic [APB_AW-1:0] REG_COUNT  = 12'h00C;
	localparam logic [APB_AW-1:0] REG_STATUS = 12'h010; // Bit 0 busy and bit 1 done

	// RAM windows hold one pixel per 32-bit word
	localparam logic [APB_AW-1:0] SRC_BASE = 12'h100;
	localparam logic [APB_AW-1:0] DST_BASE = 12'h200;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,                         // Counter issuing pixels
		ST_DRAIN = 2'd2,                         // Waiting for pipeline to empty
		ST_DONE  = 2'd3
	} tmu_state_e;

endpackage
